// ==== saleTerminalPkg.sv ====
// Catalog and basket sizes are fixed here and totals are kept in 16 bits without overflow detection
package saleTerminalPkg;

	localparam int numDigits = 4;
	localparam int numProducts = 12;
	localparam int basketDepth = 8;
	localparam int maxQuantity = 15;
	localparam int debounceCycles = 4;

	typedef logic [3:0] digitT;
	typedef logic [3:0] productIdT;
	typedef logic [15:0] priceT;
	typedef logic [3:0] quantityT;

	// Any code above nine shows as an unlit display
	localparam digitT blankDigit = 4'hF;

	// BCD codes with the first entered digit in the top nibble
	localparam logic [4*numDigits-1:0] productBarcode [numProducts] = '{
		16'h1001, 16'h1024, 16'h1234, 16'h2048, 16'h2222, 16'h3141,
		16'h4096, 16'h5005, 16'h6060, 16'h7777, 16'h8080, 16'h9999
	};
	localparam priceT productPrice [numProducts] = '{
		16'd15, 16'd40, 16'd120, 16'd8, 16'd55, 16'd314,
		16'd99, 16'd25, 16'd60, 16'd250, 16'd18, 16'd500
	};

	typedef enum logic [1:0] {stEntry, stQuantity, stInvalid} terminalStateT;
	typedef enum logic [1:0] {opNone, opAdd, opCancel, opClear} basketOpT;

	// Active low in segment order g f e d c b a
	function automatic logic [6:0] segmentOf(input digitT d);
		case (d)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

endpackage

// ==== terminalIfs.sv ====
// Plain strobes and levels between the FSM and its blocks with no handshake or back-pressure

// Digit entry and the barcode register as seen by the lookup
interface barcodeIf;
	saleTerminalPkg::digitT digits [saleTerminalPkg::numDigits];
	logic [2:0] digitCount;
	logic complete;
	logic digitStrobe;
	saleTerminalPkg::digitT digitValue;
	logic clearBarcode;

	modport control (
		output digitStrobe, digitValue, clearBarcode,
		input digitCount, complete
	);
	modport entry (
		input digitStrobe, digitValue, clearBarcode,
		output digits, digitCount, complete
	);
	modport lookup (input digits, complete);
endinterface

// One command per cycle and op idles at opNone
interface basketCmdIf;
	saleTerminalPkg::basketOpT op;
	saleTerminalPkg::productIdT productId;
	saleTerminalPkg::priceT price;
	saleTerminalPkg::quantityT quantity;

	modport master (output op, productId, price, quantity);
	modport slave (input op, productId, price, quantity);
endinterface

// ==== buttonController.sv ====
// KEY is active low and a press pulses about six cycles after the edge while SW is synchronized only
module buttonController (
	input logic CLOCK_50,
	input logic arstN,
	input logic [3:0] KEY,
	input logic [2:0] SW,
	output logic [3:0] keyPulse,
	output logic [2:0] cleanSw
);

	logic [3:0] keyMeta;
	logic [3:0] keySync;
	logic [3:0] keyStable;
	logic [2:0] swMeta;
	logic [2:0] stableCnt [4];

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			keyMeta <= '1;
			keySync <= '1;
			keyStable <= '1;
			keyPulse <= '0;
			swMeta <= '0;
			cleanSw <= '0;
			for (int i = 0; i < 4; i++) begin
				stableCnt[i] <= '0;
			end
		end else begin
			keyMeta <= KEY;
			keySync <= keyMeta;
			swMeta <= SW;
			cleanSw <= swMeta;
			keyPulse <= '0;
			for (int i = 0; i < 4; i++) begin
				// Count consecutive samples that differ from the accepted level
				if (keySync[i] == keyStable[i]) begin
					stableCnt[i] <= '0;
				end else if (int'(stableCnt[i]) == saleTerminalPkg::debounceCycles - 1) begin
					stableCnt[i] <= '0;
					keyStable[i] <= keySync[i];
					// Pulse on press only
					keyPulse[i] <= !keySync[i];
				end else begin
					stableCnt[i] <= stableCnt[i] + 3'd1;
				end
			end
		end
	end

	singlePulse: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		(keyPulse & $past(keyPulse)) == 4'b0000);

endmodule

// ==== barcodeEntry.sv ====
// Digits above nine and digits past the fourth are dropped and empty positions stay dark
module barcodeEntry (
	input logic CLOCK_50,
	input logic arstN,
	barcodeIf.entry bc,
	output logic [6:0] HEX0,
	output logic [6:0] HEX1,
	output logic [6:0] HEX2,
	output logic [6:0] HEX3
);

	logic accept;
	logic [6:0] hexOut [saleTerminalPkg::numDigits];

	assign accept = bc.digitStrobe && (bc.digitValue < 4'd10)
		&& (int'(bc.digitCount) < saleTerminalPkg::numDigits);

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			bc.digitCount <= '0;
		end else if (bc.clearBarcode) begin
			bc.digitCount <= '0;
		end else if (accept) begin
			bc.digitCount <= bc.digitCount + 3'd1;
		end
	end

	// Newest digit lands in position 0 and older ones move left
	always_ff @(posedge CLOCK_50) begin
		if (accept) begin
			bc.digits[0] <= bc.digitValue;
			for (int i = 1; i < saleTerminalPkg::numDigits; i++) begin
				bc.digits[i] <= bc.digits[i-1];
			end
		end
	end

	assign bc.complete = (int'(bc.digitCount) == saleTerminalPkg::numDigits);

	always_comb begin
		for (int i = 0; i < saleTerminalPkg::numDigits; i++) begin
			hexOut[i] = saleTerminalPkg::segmentOf((int'(bc.digitCount) > i) ?
				bc.digits[i] : saleTerminalPkg::blankDigit);
		end
	end

	assign HEX0 = hexOut[0];
	assign HEX1 = hexOut[1];
	assign HEX2 = hexOut[2];
	assign HEX3 = hexOut[3];

	countBound: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		int'(bc.digitCount) <= saleTerminalPkg::numDigits);

endmodule

// ==== productCatalog.sv ====
// Purely combinational and the outputs mean something only while valid is high
module productCatalog (
	barcodeIf.lookup bc,
	output saleTerminalPkg::productIdT productId,
	output saleTerminalPkg::priceT price,
	output logic valid
);

	logic [4*saleTerminalPkg::numDigits-1:0] code;
	logic [saleTerminalPkg::numProducts-1:0] hit;

	// Oldest digit ends up in the top nibble
	always_comb begin
		for (int i = 0; i < saleTerminalPkg::numDigits; i++) begin
			code[4*i +: 4] = bc.digits[i];
		end
	end

	always_comb begin
		productId = '0;
		price = '0;
		for (int p = 0; p < saleTerminalPkg::numProducts; p++) begin
			hit[p] = (code == saleTerminalPkg::productBarcode[p]);
		end
		for (int p = 0; p < saleTerminalPkg::numProducts; p++) begin
			if (hit[p]) begin
				productId = 4'(p);
				price = saleTerminalPkg::productPrice[p];
			end
		end
	end

	// Duplicate codes in the table would count as unknown
	assign valid = bc.complete && $onehot(hit);

endmodule

// ==== terminalFsm.sv ====
// Acts on key pulses one cycle later and issues at most one basket command per pulse
module terminalFsm (
	input logic CLOCK_50,
	input logic arstN,
	input logic [3:0] keyPulse,
	input logic [2:0] cleanSw,
	barcodeIf.control bc,
	input logic valid,
	input saleTerminalPkg::productIdT productId,
	input saleTerminalPkg::priceT price,
	basketCmdIf.master cmd,
	output saleTerminalPkg::terminalStateT state
);

	logic cmdMode;
	logic [1:0] keyIdx;

	assign cmdMode = cleanSw[0];

	// Lowest pressed key wins
	always_comb begin
		keyIdx = 2'd0;
		for (int k = 3; k >= 0; k--) begin
			if (keyPulse[k]) keyIdx = 2'(k);
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			state <= saleTerminalPkg::stEntry;
			cmd.op <= saleTerminalPkg::opNone;
			bc.digitStrobe <= 1'b0;
			bc.clearBarcode <= 1'b0;
		end else begin
			cmd.op <= saleTerminalPkg::opNone;
			bc.digitStrobe <= 1'b0;
			bc.clearBarcode <= 1'b0;
			case (state)
				saleTerminalPkg::stEntry: begin
					// A clear still in flight leaves complete high for one cycle
					if (bc.complete && !bc.clearBarcode) begin
						state <= valid ? saleTerminalPkg::stQuantity : saleTerminalPkg::stInvalid;
					end else if (!cmdMode) begin
						bc.digitStrobe <= |keyPulse;
					end else if (keyPulse[2]) begin
						cmd.op <= saleTerminalPkg::opCancel;
					end else if (keyPulse[3]) begin
						if (bc.digitCount != 3'd0) bc.clearBarcode <= 1'b1;
						else cmd.op <= saleTerminalPkg::opClear;
					end
				end
				saleTerminalPkg::stQuantity: begin
					if (cmdMode && (keyPulse[0] || keyPulse[3])) begin
						if (keyPulse[0]) cmd.op <= saleTerminalPkg::opAdd;
						bc.clearBarcode <= 1'b1;
						state <= saleTerminalPkg::stEntry;
					end
				end
				saleTerminalPkg::stInvalid: begin
					if (cmdMode && keyPulse[3]) begin
						bc.clearBarcode <= 1'b1;
						state <= saleTerminalPkg::stEntry;
					end
				end
				default: state <= saleTerminalPkg::stEntry;
			endcase
		end
	end

	// Product is tracked while in entry and held through quantity setting
	always_ff @(posedge CLOCK_50) begin
		bc.digitValue <= {cleanSw[2:1], keyIdx};
		if (state == saleTerminalPkg::stEntry) begin
			cmd.productId <= productId;
			cmd.price <= price;
			cmd.quantity <= 4'd1;
		end else if (state == saleTerminalPkg::stQuantity && cmdMode && keyPulse[1]
				&& cmd.quantity != 4'(saleTerminalPkg::maxQuantity)) begin
			cmd.quantity <= cmd.quantity + 4'd1;
		end
	end

	addNeedsValid: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		cmd.op == saleTerminalPkg::opAdd |-> valid);

endmodule

// ==== basketController.sv ====
// Adds to a full basket with a new product are dropped and the total follows the lines by one cycle
module basketController (
	input logic CLOCK_50,
	input logic arstN,
	basketCmdIf.slave cmd,
	output logic [3:0] lineCount,
	output logic full,
	output saleTerminalPkg::priceT totalPrice
);

	saleTerminalPkg::productIdT lineId [saleTerminalPkg::basketDepth];
	saleTerminalPkg::quantityT lineQty [saleTerminalPkg::basketDepth];
	saleTerminalPkg::priceT linePrice [saleTerminalPkg::basketDepth];
	logic hit;
	logic [2:0] hitIdx;
	logic [4:0] qtySum;
	saleTerminalPkg::priceT sum;

	assign full = (int'(lineCount) == saleTerminalPkg::basketDepth);

	// Oldest line holding the same product
	always_comb begin
		hit = 1'b0;
		hitIdx = 3'd0;
		for (int i = saleTerminalPkg::basketDepth - 1; i >= 0; i--) begin
			if (i < int'(lineCount) && lineId[i] == cmd.productId) begin
				hit = 1'b1;
				hitIdx = 3'(i);
			end
		end
	end

	assign qtySum = {1'b0, lineQty[hitIdx]} + {1'b0, cmd.quantity};

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			lineCount <= '0;
		end else begin
			case (cmd.op)
				saleTerminalPkg::opAdd: if (!hit && !full) lineCount <= lineCount + 4'd1;
				saleTerminalPkg::opCancel: if (lineCount != 4'd0) lineCount <= lineCount - 4'd1;
				saleTerminalPkg::opClear: lineCount <= '0;
				default: lineCount <= lineCount;
			endcase
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (cmd.op == saleTerminalPkg::opAdd) begin
			if (hit) begin
				lineQty[hitIdx] <= (int'(qtySum) > saleTerminalPkg::maxQuantity) ?
					4'(saleTerminalPkg::maxQuantity) : qtySum[3:0];
			end else if (!full) begin
				lineId[lineCount[2:0]] <= cmd.productId;
				lineQty[lineCount[2:0]] <= cmd.quantity;
				linePrice[lineCount[2:0]] <= cmd.price;
			end
		end
	end

	always_comb begin
		sum = '0;
		for (int i = 0; i < saleTerminalPkg::basketDepth; i++) begin
			if (i < int'(lineCount)) sum = sum + 16'(lineQty[i]) * linePrice[i];
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) totalPrice <= '0;
		else totalPrice <= sum;
	end

	depthBound: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		int'(lineCount) <= saleTerminalPkg::basketDepth);

endmodule

// ==== saleTerminal.sv ====
// Board top with active-low KEY and SW[0] choosing digit or command mode and LEDR bits 3 and 8 unused
module saleTerminal (
	input logic CLOCK_50,
	input logic arstN,
	input logic [3:0] KEY,
	input logic [2:0] SW,
	output logic [6:0] HEX0,
	output logic [6:0] HEX1,
	output logic [6:0] HEX2,
	output logic [6:0] HEX3,
	output logic [9:0] LEDR,
	output logic [15:0] totalPrice
);

	logic [3:0] keyPulse;
	logic [2:0] cleanSw;
	logic valid;
	saleTerminalPkg::productIdT productId;
	saleTerminalPkg::priceT price;
	saleTerminalPkg::terminalStateT state;
	logic [3:0] lineCount;
	logic full;

	barcodeIf bc ();
	basketCmdIf cmd ();

	buttonController buttonControllerInst (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.KEY(KEY),
		.SW(SW),
		.keyPulse(keyPulse),
		.cleanSw(cleanSw)
	);

	barcodeEntry barcodeEntryInst (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.bc(bc.entry),
		.HEX0(HEX0),
		.HEX1(HEX1),
		.HEX2(HEX2),
		.HEX3(HEX3)
	);

	productCatalog productCatalogInst (
		.bc(bc.lookup),
		.productId(productId),
		.price(price),
		.valid(valid)
	);

	terminalFsm terminalFsmInst (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.keyPulse(keyPulse),
		.cleanSw(cleanSw),
		.bc(bc.control),
		.valid(valid),
		.productId(productId),
		.price(price),
		.cmd(cmd.master),
		.state(state)
	);

	basketController basketControllerInst (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.cmd(cmd.slave),
		.lineCount(lineCount),
		.full(full),
		.totalPrice(totalPrice)
	);

	// State shown one-hot
	assign LEDR[0] = (state == saleTerminalPkg::stEntry);
	assign LEDR[1] = (state == saleTerminalPkg::stQuantity);
	assign LEDR[2] = (state == saleTerminalPkg::stInvalid);
	assign LEDR[3] = 1'b0;
	assign LEDR[7:4] = lineCount;
	assign LEDR[8] = 1'b0;
	assign LEDR[9] = full;

endmodule

// ==== tbClock.sv ====
// Clock period is 10 time units and reset stays low for the first three rising edges
module tbClock (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		arstN = 1'b0;
		repeat (3) @(posedge clk);
		arstN <= 1'b1;
	end

endmodule

// ==== saleTerminalTb.sv ====
// Reads saleTerminalInput.txt from the working directory and holds each press for 10 cycles
module saleTerminalTb;

	localparam int maxSteps = 128;
	localparam int fieldsPerStep = 5;
	localparam int holdCycles = 10;
	localparam int settleCycles = 20;

	logic clk;
	logic arstN;
	logic [3:0] KEY;
	logic [2:0] SW;
	logic [6:0] HEX0;
	logic [6:0] HEX1;
	logic [6:0] HEX2;
	logic [6:0] HEX3;
	logic [9:0] LEDR;
	logic [15:0] totalPrice;

	// Five words per step for key, SW, digits, LEDR and total
	logic [15:0] stepData [fieldsPerStep*maxSteps];
	int numSteps;
	logic loaded;

	tbClock clockGen (
		.clk(clk),
		.arstN(arstN)
	);

	saleTerminal i_dut (
		.CLOCK_50(clk),
		.arstN(arstN),
		.KEY(KEY),
		.SW(SW),
		.HEX0(HEX0),
		.HEX1(HEX1),
		.HEX2(HEX2),
		.HEX3(HEX3),
		.LEDR(LEDR),
		.totalPrice(totalPrice)
	);

	// Active low in order g f e d c b a with anything above nine dark
	function automatic logic [6:0] expectedSegments(input logic [3:0] digit);
		logic [6:0] pattern;
		case (digit)
			4'd0: pattern = 7'h40;
			4'd1: pattern = 7'h79;
			4'd2: pattern = 7'h24;
			4'd3: pattern = 7'h30;
			4'd4: pattern = 7'h19;
			4'd5: pattern = 7'h12;
			4'd6: pattern = 7'h02;
			4'd7: pattern = 7'h78;
			4'd8: pattern = 7'h00;
			4'd9: pattern = 7'h10;
			default: pattern = 7'h7F;
		endcase
		return pattern;
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic checkValue(input string name, input logic [15:0] got,
			input logic [15:0] expected);
		assert (got == expected) else begin
			abortRun($sformatf("MISMATCH at %0t: %s expected 0x%0h got 0x%0h",
				$time, name, expected, got));
		end
	endtask

	// Key 4 means no press and only SW is applied
	task automatic runStep(input int step);
		int base;
		logic [3:0] keyIdx;
		logic [15:0] digits;
		base = fieldsPerStep * step;
		keyIdx = stepData[base][3:0];
		digits = stepData[base+2];
		@(posedge clk);
		SW <= stepData[base+1][2:0];
		if (keyIdx < 4'd4) KEY <= ~(4'b0001 << keyIdx[1:0]);
		repeat (holdCycles) @(posedge clk);
		KEY <= 4'b1111;
		repeat (settleCycles) @(posedge clk);
		@(negedge clk);
		checkValue("HEX0", 16'(HEX0), 16'(expectedSegments(digits[3:0])));
		checkValue("HEX1", 16'(HEX1), 16'(expectedSegments(digits[7:4])));
		checkValue("HEX2", 16'(HEX2), 16'(expectedSegments(digits[11:8])));
		checkValue("HEX3", 16'(HEX3), 16'(expectedSegments(digits[15:12])));
		checkValue("LEDR", 16'(LEDR), stepData[base+3]);
		checkValue("totalPrice", totalPrice, stepData[base+4]);
	endtask

	initial begin
		KEY = 4'b1111;
		SW = 3'b000;
		loaded = 1'b0;
		numSteps = 0;
		$readmemh("saleTerminalInput.txt", stepData);
		// A key field of F ends the list
		while (numSteps < maxSteps && stepData[fieldsPerStep*numSteps] != 16'h000F) begin
			numSteps++;
		end
		if (numSteps == 0 || numSteps == maxSteps) begin
			abortRun("Input file is missing, empty or has no end marker");
		end
		loaded = 1'b1;
		wait (arstN === 1'b1);
		for (int s = 0; s < numSteps; s++) begin
			runStep(s);
		end
		$display("Test OK");
		$finish;
	end

	// Each step takes about 32 cycles
	initial begin
		wait (loaded);
		repeat (numSteps * 40 + 100) @(posedge clk);
		abortRun("Timeout: the test steps did not finish in time");
	end

endmodule

// ==== saleTerminalInput.txt ====
// key (0-3 press, 4 none, F ends)  SW  digits HEX3..HEX0 (F dark)  LEDR  totalPrice
// all values hex, digit d is key d%4 with SW[2:1] = d/4
4 0 FFFF 001 0000
// 1 0, a ten that is ignored, 2 4, then quantity 3
1 0 FFF1 001 0000
0 0 FF10 001 0000
2 4 FF10 001 0000
2 0 F102 001 0000
0 2 1024 002 0000
1 1 1024 002 0000
1 1 1024 002 0000
0 1 FFFF 011 0078
// Unknown 1111, confirm does nothing
1 0 FFF1 011 0078
1 0 FF11 011 0078
1 0 F111 011 0078
1 0 1111 014 0078
0 1 1111 014 0078
3 1 FFFF 011 0078
// 1024 again with quantity 13, line stops at 15
1 0 FFF1 011 0078
0 0 FF10 011 0078
2 0 F102 011 0078
0 2 1024 012 0078
1 1 1024 012 0078
1 1 1024 012 0078
1 1 1024 012 0078
1 1 1024 012 0078
1 1 1024 012 0078
1 1 1024 012 0078
1 1 1024 012 0078
1 1 1024 012 0078
1 1 1024 012 0078
1 1 1024 012 0078
1 1 1024 012 0078
1 1 1024 012 0078
0 1 FFFF 011 0258
// Seven more products fill the basket
1 0 FFF1 011 0258
0 0 FF10 011 0258
0 0 F100 011 0258
1 0 1001 012 0258
0 1 FFFF 021 0267
1 0 FFF1 021 0267
2 0 FF12 021 0267
3 0 F123 021 0267
0 2 1234 022 0267
0 1 FFFF 031 02DF
2 0 FFF2 031 02DF
0 0 FF20 031 02DF
0 2 F204 031 02DF
0 4 2048 032 02DF
0 1 FFFF 041 02E7
2 0 FFF2 041 02E7
2 0 FF22 041 02E7
2 0 F222 041 02E7
2 0 2222 042 02E7
0 1 FFFF 051 031E
3 0 FFF3 051 031E
1 0 FF31 051 031E
0 2 F314 051 031E
1 0 3141 052 031E
0 1 FFFF 061 0458
0 2 FFF4 061 0458
0 0 FF40 061 0458
1 4 F409 061 0458
2 2 4096 062 0458
0 1 FFFF 071 04BB
1 2 FFF5 071 04BB
0 0 FF50 071 04BB
0 0 F500 071 04BB
1 2 5005 072 04BB
0 1 FFFF 281 04D4
// Ninth product is dropped
2 2 FFF6 281 04D4
0 0 FF60 281 04D4
2 2 F606 281 04D4
0 0 6060 282 04D4
0 1 FFFF 281 04D4
// Cancel newest line, then clear the basket
2 1 FFFF 071 04BB
3 1 FFFF 001 0000
F 0 0000 000 0000

// ==== list.f ====
saleTerminalPkg.sv
terminalIfs.sv
buttonController.sv
barcodeEntry.sv
productCatalog.sv
terminalFsm.sv
basketController.sv
saleTerminal.sv
tbClock.sv
saleTerminalTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module saleTerminalTb -o simv \
	&& ./obj_dir/simv 2>&1 | tee sim.log \
	|| echo "build or simulation run failed"
grep -qx "Test OK" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
